/* beam_params.svh */
// width and count constants for the beam combiner, included by every file that sizes a vector
`ifndef BEAM_PARAMS_SVH
`define BEAM_PARAMS_SVH

// four antenna channels are combined into one beam
`define BEAM_CHANNELS 4

// each beat carries eight samples in a 128-bit lane per component
`define BEAM_SAMPLES 8

// samples are signed 16-bit values for both re and im
`define BEAM_SAMPLE_W 16

// weights are signed Q1.7 fractions, so 127 is just under one
`define BEAM_WEIGHT_W 8
`define BEAM_WEIGHT_FRAC 7

// a scaled complex product needs 18 bits to hold the worst case without loss
`define BEAM_PROD_W 18

// four 18-bit products summed need two more bits of headroom
`define BEAM_SUM_W 20

`endif

/* beam_pkg.sv */
// shared datapath types for the beam combiner, referenced by scoped names from the RTL modules
`include "beam_params.svh"

package beam_pkg;

    // one signed component of an antenna sample
    typedef logic signed [`BEAM_SAMPLE_W-1:0] sample_t;

    // one signed component of a channel weight in Q1.7
    typedef logic signed [`BEAM_WEIGHT_W-1:0] weight_t;

    // one component of a weighted sample after the Q1.7 scaling
    typedef logic signed [`BEAM_PROD_W-1:0] prod_t;

    // a full complex beat with sample 0 in the low bits of each lane
    // the re and im lanes keep the 128-bit layout of the stream
    typedef struct packed {
        sample_t [`BEAM_SAMPLES-1:0] re;
        sample_t [`BEAM_SAMPLES-1:0] im;
    } iq_beat_t;

    // complex weight of one channel, applied to every sample of its beat
    typedef struct packed {
        weight_t re;
        weight_t im;
    } cweight_t;

    // a channel beat after the complex multiply and scaling
    // it is wider than a sample so the four-way sum sees no wrap
    typedef struct packed {
        prod_t [`BEAM_SAMPLES-1:0] re;
        prod_t [`BEAM_SAMPLES-1:0] im;
    } prod_beat_t;

endpackage

/* beam_control.sv */
// handshake and sideband pipeline of the beam combiner, instanced once by the top level
`timescale 1ns/1ns
`include "beam_params.svh"

module beam_control (
    input  logic                      clock,
    input  logic                      resetn,
    input  logic [`BEAM_CHANNELS-1:0] chan_valid,
    input  logic                      chan_last,
    input  logic                      out_ready,
    output logic                      advance,
    output logic                      in_ready,
    output logic                      out_valid,
    output logic                      out_last
);

    // the datapath is three registers deep so the sideband is too
    localparam int DEPTH = 3;

    // stays low through reset and for the first cycle after it
    logic running;

    // a beat is taken only when every channel offers one at once
    logic accept;

    // valid and tlast of the beat held in each datapath stage
    logic [DEPTH-1:0] valid_pipe;
    logic [DEPTH-1:0] last_pipe;

    // the whole pipeline moves only when the consumer can take a beat
    // an idle stage may still shift, it just carries a cleared valid bit
    assign advance = out_ready;

    // the input side mirrors the output side once the block is running
    assign in_ready = out_ready & running;

    // the only place where the channel valid bits are looked at
    assign accept = (&chan_valid) & in_ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            running    <= 1'b0;
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            running <= 1'b1;
            if (advance) begin
                // shift in a new item each advancing edge, empty or not
                valid_pipe <= {valid_pipe[DEPTH-2:0], accept};
                // tlast comes from channel 0 and only counts with an accepted beat
                last_pipe  <= {last_pipe[DEPTH-2:0], accept & chan_last};
            end
        end
    end

    // the last stage lines up with the registered output beat
    assign out_valid = valid_pipe[DEPTH-1];
    assign out_last  = last_pipe[DEPTH-1];

endmodule

/* channel_weighter.sv */
// two-stage complex weighting of one channel beat, instanced once per antenna channel
`timescale 1ns/1ns
`include "beam_params.svh"

module channel_weighter (
    input  logic                   clock,
    input  logic                   advance,
    input  beam_pkg::iq_beat_t     data,
    input  beam_pkg::cweight_t     weight,
    output beam_pkg::prod_beat_t   prod
);

    // operand width for the multiply, one bit over sample plus weight
    // so that the sum of two cross products cannot wrap
    localparam int MUL_W = `BEAM_SAMPLE_W + `BEAM_WEIGHT_W + 1;

    // stage 1 holds the beat together with the weight captured alongside it
    beam_pkg::iq_beat_t data_q;
    beam_pkg::cweight_t weight_q;

    // scaled products before the stage 2 register
    beam_pkg::prod_beat_t prod_d;

    // weights are plain levels and are sampled on the same edge as the data
    // so a weight change never lands in the middle of a beat
    always_ff @(posedge clock) begin
        if (advance) begin
            data_q   <= data;
            weight_q <= weight;
        end
    end

    always_comb begin : multiply
        logic signed [MUL_W-1:0] xr;
        logic signed [MUL_W-1:0] xi;
        logic signed [MUL_W-1:0] wr;
        logic signed [MUL_W-1:0] wi;
        logic signed [MUL_W-1:0] acc_re;
        logic signed [MUL_W-1:0] acc_im;

        // the weight is the same for all eight samples of the beat
        wr = {{(MUL_W-`BEAM_WEIGHT_W){weight_q.re[`BEAM_WEIGHT_W-1]}}, weight_q.re};
        wi = {{(MUL_W-`BEAM_WEIGHT_W){weight_q.im[`BEAM_WEIGHT_W-1]}}, weight_q.im};

        for (int s = 0; s < `BEAM_SAMPLES; s++) begin
            // sign extend each sample up to the operand width first
            xr = {{(MUL_W-`BEAM_SAMPLE_W){data_q.re[s][`BEAM_SAMPLE_W-1]}}, data_q.re[s]};
            xi = {{(MUL_W-`BEAM_SAMPLE_W){data_q.im[s][`BEAM_SAMPLE_W-1]}}, data_q.im[s]};

            // real part takes re*wr minus im*wi
            acc_re = xr * wr - xi * wi;
            // imaginary part takes the two cross terms re*wi and im*wr
            acc_im = xr * wi + xi * wr;

            // dropping the seven fraction bits is an arithmetic shift
            // and rounds toward minus infinity
            // the remaining top bits are exactly one product wide
            prod_d.re[s] = acc_re[`BEAM_WEIGHT_FRAC +: `BEAM_PROD_W];
            prod_d.im[s] = acc_im[`BEAM_WEIGHT_FRAC +: `BEAM_PROD_W];
        end
    end

    // stage 2 registers the scaled products for the summer
    always_ff @(posedge clock) begin
        if (advance) begin
            prod <= prod_d;
        end
    end

endmodule

/* beam_summer.sv */
// four-way sum of the weighted channels with saturation to the output sample width
`timescale 1ns/1ns
`include "beam_params.svh"

module beam_summer (
    input  logic                                       clock,
    input  logic                                       advance,
    input  beam_pkg::prod_beat_t [`BEAM_CHANNELS-1:0] prod,
    output beam_pkg::iq_beat_t                         out_data
);

    // combined beat before the output register
    beam_pkg::iq_beat_t sum_d;

    // sign extends one scaled product to the width of the sum
    function automatic logic signed [`BEAM_SUM_W-1:0] widen(input beam_pkg::prod_t p);
        return {{(`BEAM_SUM_W-`BEAM_PROD_W){p[`BEAM_PROD_W-1]}}, p};
    endfunction

    // clamps a sum into the signed sample range
    function automatic beam_pkg::sample_t saturate(input logic signed [`BEAM_SUM_W-1:0] s);
        logic [`BEAM_SUM_W-`BEAM_SAMPLE_W:0] top;

        // the sum fits when every bit above the sample's sign bit copies it
        top = s[`BEAM_SUM_W-1:`BEAM_SAMPLE_W-1];
        if (top == '0 || top == '1) begin
            return s[`BEAM_SAMPLE_W-1:0];
        end else if (s[`BEAM_SUM_W-1]) begin
            return {1'b1, {(`BEAM_SAMPLE_W-1){1'b0}}};
        end else begin
            return {1'b0, {(`BEAM_SAMPLE_W-1){1'b1}}};
        end
    endfunction

    always_comb begin : combine
        logic signed [`BEAM_SUM_W-1:0] acc_re;
        logic signed [`BEAM_SUM_W-1:0] acc_im;

        for (int s = 0; s < `BEAM_SAMPLES; s++) begin
            acc_re = '0;
            acc_im = '0;
            // each sample position is summed on its own across the channels
            for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
                acc_re = acc_re + widen(prod[ch].re[s]);
                acc_im = acc_im + widen(prod[ch].im[s]);
            end
            sum_d.re[s] = saturate(acc_re);
            sum_d.im[s] = saturate(acc_im);
        end
    end

    // the output beat holds its value while the consumer stalls
    always_ff @(posedge clock) begin
        if (advance) begin
            out_data <= sum_d;
        end
    end

endmodule

/* beam_former.sv */
// top level of the four-channel beam combiner, the block that a system or testbench instances
`timescale 1ns/1ns
`include "beam_params.svh"

module beam_former (
    input  logic                                     clock,
    input  logic                                     resetn,
    input  logic [`BEAM_CHANNELS-1:0]                chan_valid,
    input  beam_pkg::iq_beat_t [`BEAM_CHANNELS-1:0] chan_data,
    input  beam_pkg::cweight_t [`BEAM_CHANNELS-1:0] chan_weight,
    input  logic                                     chan_last,
    output logic                                     in_ready,
    output logic                                     out_valid,
    output beam_pkg::iq_beat_t                       out_data,
    output logic                                     out_last,
    input  logic                                     out_ready
);

    // common enable for every datapath register in the block
    logic advance;

    // weighted beat of each channel on its way to the summer
    beam_pkg::prod_beat_t [`BEAM_CHANNELS-1:0] chan_prod;

    // handshake decisions and the valid and tlast sideband
    // everything here is three stages deep to match the datapath
    beam_control control_i (
        .clock      (clock),
        .resetn     (resetn),
        .chan_valid (chan_valid),
        .chan_last  (chan_last),
        .out_ready  (out_ready),
        .advance    (advance),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_last   (out_last)
    );

    // one weighter per antenna channel, each with its own complex weight
    // they take up the first two stages of the pipeline
    for (genvar ch = 0; ch < `BEAM_CHANNELS; ch++) begin : gen_chan
        channel_weighter weighter_i (
            .clock   (clock),
            .advance (advance),
            .data    (chan_data[ch]),
            .weight  (chan_weight[ch]),
            .prod    (chan_prod[ch])
        );
    end

    // the third stage adds the channels and drives the output beat
    beam_summer summer_i (
        .clock    (clock),
        .advance  (advance),
        .prod     (chan_prod),
        .out_data (out_data)
    );

endmodule

/* beam_checker.sv */
// checker for the beam combiner testbench, predicts each output beat from accepted inputs and compares
`timescale 1ns/1ns
`include "beam_params.svh"

module beam_checker (
    input logic                                    clock,
    input logic                                    resetn,
    input logic [`BEAM_CHANNELS-1:0]               chan_valid,
    input beam_pkg::iq_beat_t [`BEAM_CHANNELS-1:0] chan_data,
    input beam_pkg::cweight_t [`BEAM_CHANNELS-1:0] chan_weight,
    input logic                                    chan_last,
    input logic                                    in_ready,
    input logic                                    out_valid,
    input beam_pkg::iq_beat_t                      out_data,
    input logic                                    out_last,
    input logic                                    out_ready
);

    // predicted beats and their tlast, oldest first
    beam_pkg::iq_beat_t expq[$];
    logic               lastq[$];

    int   errors       = 0;
    int   transfers    = 0;
    int   passed_tests = 0;
    int   failed_tests = 0;
    int   reset_edges  = 0;
    logic was_reset    = 1'b0;

    // the output beat seen on a stalled edge, which must still be there on the next one
    logic               held_valid = 1'b0;
    beam_pkg::iq_beat_t held_data;

    // rounds toward minus infinity, unlike the plain divide
    function automatic int floor_div(input int p);
        int d;
        int q;
        d = 1 << `BEAM_WEIGHT_FRAC;
        q = p / d;
        if (p % d != 0 && p < 0) begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic beam_pkg::sample_t clamp_sample(input int v);
        int hi;
        int lo;
        hi = (1 << (`BEAM_SAMPLE_W - 1)) - 1;
        lo = -(1 << (`BEAM_SAMPLE_W - 1));
        if (v > hi) begin
            return beam_pkg::sample_t'(hi);
        end else if (v < lo) begin
            return beam_pkg::sample_t'(lo);
        end
        return beam_pkg::sample_t'(v);
    endfunction

    // complex product per channel, scaled by 128, summed over channels, then clamped
    function automatic beam_pkg::iq_beat_t expected_beat(
        input beam_pkg::iq_beat_t [`BEAM_CHANNELS-1:0] d,
        input beam_pkg::cweight_t [`BEAM_CHANNELS-1:0] w);
        beam_pkg::iq_beat_t e;
        int sr;
        int si;
        int xr;
        int xi;
        int wr;
        int wi;
        for (int s = 0; s < `BEAM_SAMPLES; s++) begin
            sr = 0;
            si = 0;
            for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
                xr = int'(d[ch].re[s]);
                xi = int'(d[ch].im[s]);
                wr = int'(w[ch].re);
                wi = int'(w[ch].im);
                sr += floor_div(xr * wr - xi * wi);
                si += floor_div(xr * wi + xi * wr);
            end
            e.re[s] = clamp_sample(sr);
            e.im[s] = clamp_sample(si);
        end
        return e;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic compare_beat(input beam_pkg::iq_beat_t got, input beam_pkg::iq_beat_t exp);
        for (int s = 0; s < `BEAM_SAMPLES; s++) begin
            if (got.re[s] !== exp.re[s]) begin
                report_mismatch($sformatf("sample %0d re is %0d, expected %0d",
                                          s, got.re[s], exp.re[s]));
            end
            if (got.im[s] !== exp.im[s]) begin
                report_mismatch($sformatf("sample %0d im is %0d, expected %0d",
                                          s, got.im[s], exp.im[s]));
            end
        end
    endtask

    // DUT outputs are read at the rising edge, before the edge updates them
    always @(posedge clock) begin : watch
        beam_pkg::iq_beat_t exp_beat;
        logic               exp_last;
        // out_valid and in_ready stay low in reset and on the first edge after it
        if ((!resetn && reset_edges > 0) || was_reset) begin
            if (out_valid || in_ready) begin
                report_mismatch("out_valid or in_ready is high during or just after reset");
            end
        end
        if (!resetn) begin
            reset_edges++;
        end
        was_reset = !resetn;
        if (resetn) begin
            if (!out_ready && in_ready) begin
                report_mismatch("in_ready is high while out_ready is low");
            end
            if (out_last && !out_valid) begin
                report_mismatch("out_last is high without out_valid");
            end
            if (held_valid && (!out_valid || out_data !== held_data)) begin
                report_mismatch("output beat changed while the consumer stalled");
            end
            held_valid = out_valid && !out_ready;
            held_data  = out_data;
            if (out_valid && out_ready) begin
                transfers++;
                if (expq.size() == 0) begin
                    report_problem($sformatf("unexpected output beat at %0t ns with no input",
                                             $time));
                end else begin
                    exp_beat = expq.pop_front();
                    exp_last = lastq.pop_front();
                    compare_beat(out_data, exp_beat);
                    if (out_last !== exp_last) begin
                        report_mismatch($sformatf("out_last is %0b, expected %0b",
                                                  out_last, exp_last));
                    end
                end
            end
            if ((&chan_valid) && in_ready) begin
                expq.push_back(expected_beat(chan_data, chan_weight));
                lastq.push_back(chan_last);
            end
        end
    end

    function automatic int pending_beats();
        return expq.size();
    endfunction

    task automatic finish_test(input int num, input int beats);
        if (expq.size() != 0) begin
            report_problem($sformatf("test %0d: missing output, %0d accepted beats never came out",
                                     num, expq.size()));
            expq.delete();
            lastq.delete();
        end
        if (transfers != beats) begin
            report_problem($sformatf("test %0d: %0d output beats for %0d beats sent",
                                     num, transfers, beats));
        end
        if (errors == 0) begin
            $display("test %0d ok, %0d beats", num, beats);
            passed_tests++;
        end else begin
            $display("test %0d had %0d errors", num, errors);
            failed_tests++;
        end
        errors    = 0;
        transfers = 0;
    endtask

    task automatic report_summary();
        $display("summary: %0d tests, %0d ok, %0d with errors",
                 passed_tests + failed_tests, passed_tests, failed_tests);
    endtask

    function automatic logic all_ok();
        return (failed_tests == 0) && (passed_tests > 0);
    endfunction

endmodule

/* beam_former_tb.sv */
// testbench top that drives a table of bursts into the beam combiner and prints the verdict
`timescale 1ns/1ns
`include "beam_params.svh"

module beam_former_tb;

    // how the samples of a test are made
    localparam int MODE_RANDOM  = 0;
    localparam int MODE_FIXED   = 1;
    localparam int MODE_EXTREME = 2;

    // with out_ready held high the three-stage pipeline empties well within this
    localparam int DRAIN_CYCLES = 10;

    // one row of the stimulus table
    // a low bit of ready_pattern stalls the output on that cycle of the test
    typedef struct packed {
        int                                      num;
        beam_pkg::cweight_t [`BEAM_CHANNELS-1:0] weight;
        int                                      mode;
        int                                      beats;
        logic [`BEAM_CHANNELS-1:0]               valid_mask;
        logic [31:0]                             ready_pattern;
    } test_entry_t;

    logic                                    clock;
    logic                                    resetn;
    logic [`BEAM_CHANNELS-1:0]               chan_valid;
    beam_pkg::iq_beat_t [`BEAM_CHANNELS-1:0] chan_data;
    beam_pkg::cweight_t [`BEAM_CHANNELS-1:0] chan_weight;
    logic                                    chan_last;
    logic                                    in_ready;
    logic                                    out_valid;
    beam_pkg::iq_beat_t                      out_data;
    logic                                    out_last;
    logic                                    out_ready;

    test_entry_t tests[$];
    int          total_beats  = 0;
    int          limit_cycles = 0;
    int          cycle_count  = 0;

    beam_former beam_former_i (
        .clock       (clock),
        .resetn      (resetn),
        .chan_valid  (chan_valid),
        .chan_data   (chan_data),
        .chan_weight (chan_weight),
        .chan_last   (chan_last),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_ready   (out_ready)
    );

    // the checker sees every port of the DUT and does all the comparing
    beam_checker checker_i (
        .clock       (clock),
        .resetn      (resetn),
        .chan_valid  (chan_valid),
        .chan_data   (chan_data),
        .chan_weight (chan_weight),
        .chan_last   (chan_last),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_ready   (out_ready)
    );

    // 4 ns clock period
    always #2 clock = ~clock;

    // the limit is only armed once the table is loaded
    always @(posedge clock) begin
        cycle_count++;
        if (limit_cycles > 0 && cycle_count >= limit_cycles) begin
            $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic beam_pkg::cweight_t make_weight(input int re, input int im);
        beam_pkg::cweight_t w;
        w.re = beam_pkg::weight_t'(re);
        w.im = beam_pkg::weight_t'(im);
        return w;
    endfunction

    task automatic add_test(input int num, input beam_pkg::cweight_t w0, w1, w2, w3,
                            input int mode, input int beats,
                            input logic [`BEAM_CHANNELS-1:0] mask, input logic [31:0] pattern);
        test_entry_t e;
        e.num           = num;
        e.weight[0]     = w0;
        e.weight[1]     = w1;
        e.weight[2]     = w2;
        e.weight[3]     = w3;
        e.mode          = mode;
        e.beats         = beats;
        e.valid_mask    = mask;
        e.ready_pattern = pattern;
        tests.push_back(e);
        total_beats += beats;
    endtask

    // fills every channel with a new beat
    // b is the beat index within the test
    task automatic make_beat(input int mode, input int b);
        for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
            for (int s = 0; s < `BEAM_SAMPLES; s++) begin
                case (mode)
                    MODE_RANDOM: begin
                        chan_data[ch].re[s] = beam_pkg::sample_t'($urandom());
                        chan_data[ch].im[s] = beam_pkg::sample_t'($urandom());
                    end
                    MODE_FIXED: begin
                        chan_data[ch].re[s] = beam_pkg::sample_t'(12000);
                        chan_data[ch].im[s] = beam_pkg::sample_t'(-7000);
                    end
                    default: begin
                        // full-scale values whose sign flips from sample to sample
                        if ((s + b) % 2 == 0) begin
                            chan_data[ch].re[s] = beam_pkg::sample_t'(32767);
                            chan_data[ch].im[s] = beam_pkg::sample_t'(-32768);
                        end else begin
                            chan_data[ch].re[s] = beam_pkg::sample_t'(-32768);
                            chan_data[ch].im[s] = beam_pkg::sample_t'(32767);
                        end
                    end
                endcase
            end
        end
    endtask

    // sends one burst, then drains the pipeline and closes the test in the checker
    task automatic run_test(input test_entry_t e);
        int   sent;
        int   cyc;
        int   drain;
        logic fresh;
        sent  = 0;
        cyc   = 0;
        drain = 0;
        fresh = 1'b1;
        while (sent < e.beats) begin
            @(negedge clock);
            chan_weight = e.weight;
            out_ready   = e.ready_pattern[cyc % 32];
            // a beat stays on the inputs until it has been taken
            if (fresh) begin
                make_beat(e.mode, sent);
                fresh = 1'b0;
            end
            // odd cycles of a masked test offer an incomplete set of channels
            if (e.valid_mask != '1 && cyc % 2 == 1) begin
                chan_valid = e.valid_mask;
            end else begin
                chan_valid = '1;
            end
            chan_last = (sent == e.beats - 1);
            // in_ready has settled by now and holds until the next rising edge
            #1;
            if ((&chan_valid) && in_ready) begin
                sent++;
                fresh = 1'b1;
            end
            cyc++;
        end
        @(negedge clock);
        chan_valid = '0;
        chan_last  = 1'b0;
        out_ready  = 1'b1;
        // beats that are still owed after this wait count as missing output
        while (checker_i.pending_beats() != 0 && drain < DRAIN_CYCLES) begin
            @(negedge clock);
            drain++;
        end
        // a few idle cycles so that a stray extra beat would still be seen
        repeat (6) @(negedge clock);
        checker_i.finish_test(e.num, e.beats);
    endtask

    initial begin
        clock       = 1'b0;
        resetn      = 1'b0;
        chan_valid  = '0;
        chan_data   = '0;
        chan_weight = '0;
        chan_last   = 1'b0;
        out_ready   = 1'b1;
        void'($urandom(32'h3ff3));

        // num, four channel weights, mode, beats, partial-valid mask, out_ready pattern
        add_test(1, make_weight(64, 0), make_weight(64, 0), make_weight(64, 0),
                 make_weight(64, 0), MODE_RANDOM, 8, 4'hf, 32'hffff_ffff);
        add_test(2, make_weight(100, -37), make_weight(-64, 90), make_weight(-128, 5),
                 make_weight(17, -128), MODE_RANDOM, 8, 4'hf, 32'hffff_ffff);
        add_test(3, make_weight(127, 0), make_weight(127, 0), make_weight(127, 0),
                 make_weight(127, 0), MODE_EXTREME, 4, 4'hf, 32'hffff_ffff);
        add_test(4, make_weight(-128, -128), make_weight(-128, -128), make_weight(-128, -128),
                 make_weight(-128, -128), MODE_EXTREME, 4, 4'hf, 32'hffff_ffff);
        add_test(5, make_weight(33, -70), make_weight(-90, 12), make_weight(5, 5),
                 make_weight(-1, 127), MODE_RANDOM, 12, 4'hf, 32'hf0f3_c0ff);
        add_test(6, make_weight(64, -64), make_weight(20, 30), make_weight(-40, 10),
                 make_weight(0, -90), MODE_FIXED, 6, 4'b1011, 32'hffff_ffff);
        add_test(7, make_weight(-77, 44), make_weight(90, 90), make_weight(-3, -120),
                 make_weight(60, -25), MODE_RANDOM, 10, 4'b0111, 32'hff3c_f0e7);
        limit_cycles = 16 + 20 * total_beats + 100;

        repeat (16) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;

        foreach (tests[t]) begin
            run_test(tests[t]);
        end

        checker_i.report_summary();
        if (checker_i.all_ok()) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
beam_pkg.sv
beam_control.sv
channel_weighter.sv
beam_summer.sv
beam_former.sv
beam_checker.sv
beam_former_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the beam combiner testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module beam_former_tb -o beam_former_sim

./obj_dir/beam_former_sim > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures, see sim.log"
exit 0
